/* rtl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // from execute
    typedef struct packed {
        logic        hold;        // mul, div, mem wait or pending jalr
        logic        redirect;
        logic [31:0] redirect_pc;
    } ctrl_t;

    // boot image write
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } load_t;

endpackage

`default_nettype wire

/* rtl/fetch_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,
    input  logic     flush
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign out_valid = (count != '0);
    assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready; // full queue takes a write on a pop
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_merge
    import fetch_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         order_valid,
    input  bank_idx_t                    order_bank,
    output logic                         order_ready,
    input  logic       [NUM_BANKS-1:0]   rsp_valid,
    input  fetch_rsp_t [NUM_BANKS-1:0]   rsp,
    output logic       [NUM_BANKS-1:0]   rsp_ready,
    input  logic                         epoch,
    output logic                         out_valid,
    output fetch_rsp_t                   out,
    input  logic                         out_ready
);

    bank_idx_t  head;       // bank holding the oldest instruction
    fetch_rsp_t sel;
    fetch_rsp_t oq_data;
    logic       ord_in_ready;
    logic       ord_valid;
    logic       ord_pop;
    logic       stale;
    logic       oq_in_ready;
    logic       oq_valid;
    logic       pend_epoch; // epoch of everything in the order queue
    logic       epoch_d;
    logic       drain;
    logic       flush;

    fetch_fifo #(
        .payload_t (bank_idx_t),
        .DEPTH     (4)
    ) i_order_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (order_valid),
        .in_data   (order_bank),
        .in_ready  (ord_in_ready),
        .out_valid (ord_valid),
        .out_data  (head),
        .out_ready (ord_pop),
        .flush     (1'b0)
    );

    // old-epoch requests must leave before new ones enter
    assign drain       = ord_valid && (pend_epoch != epoch);
    assign order_ready = ord_in_ready && !drain;

    assign sel     = rsp[head];
    assign stale   = (sel.epoch != epoch);
    assign ord_pop = ord_valid && rsp_valid[head] && (stale || oq_in_ready);

    always_comb begin
        rsp_ready       = '0;
        rsp_ready[head] = ord_pop;
    end

    assign flush = (epoch != epoch_d); // wrong-path entries already queued for decode

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_epoch <= 1'b0;
            epoch_d    <= 1'b0;
        end else begin
            epoch_d <= epoch;
            if (order_valid && order_ready) begin
                pend_epoch <= epoch;
            end
        end
    end

    fetch_fifo #(
        .payload_t (fetch_rsp_t),
        .DEPTH     (4)
    ) i_out_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ord_pop && !stale),
        .in_data   (sel),
        .in_ready  (oq_in_ready),
        .out_valid (oq_valid),
        .out_data  (oq_data),
        .out_ready (out_ready),
        .flush     (flush)
    );

    assign out_valid = oq_valid && (oq_data.epoch == epoch); // hide until flushed
    assign out       = oq_data;

endmodule

`default_nettype wire

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam int PC_WIDTH = 32;
    localparam logic [PC_WIDTH-1:0] RESET_PC = 32'h8000_0000;

    localparam int NUM_BANKS  = 4;   // power of two
    localparam int BANK_BITS  = $clog2(NUM_BANKS);
    localparam int BANK_DEPTH = 256; // words per bank
    localparam int ROW_BITS   = $clog2(BANK_DEPTH);

    typedef logic [BANK_BITS-1:0] bank_idx_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic                epoch;
    } fetch_req_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic [31:0]         instr;
        logic                epoch; // epoch of the request that fetched it
    } fetch_rsp_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_t      ctrl,
    input  logic       load_valid,
    input  load_t      load,
    output logic       out_valid,
    output fetch_rsp_t out,
    input  logic       out_ready
);

    fetch_req_t                 req;        // shared by all banks
    logic       [NUM_BANKS-1:0] req_valid;
    logic       [NUM_BANKS-1:0] req_ready;
    logic       [NUM_BANKS-1:0] rsp_valid;
    logic       [NUM_BANKS-1:0] rsp_ready;
    fetch_rsp_t [NUM_BANKS-1:0] rsp;
    logic                       order_valid;
    logic                       order_ready;
    bank_idx_t                  order_bank;
    logic                       epoch;

    pc_gen i_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .order_ready (order_ready),
        .order_valid (order_valid),
        .order_bank  (order_bank),
        .epoch       (epoch)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        imem_bank #(
            .BANK_ID (bank_idx_t'(i))
        ) i_imem_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_valid  (req_valid[i]),
            .req        (req),
            .req_ready  (req_ready[i]),
            .rsp_valid  (rsp_valid[i]),
            .rsp        (rsp[i]),
            .rsp_ready  (rsp_ready[i]),
            .load_valid (load_valid),
            .load       (load)
        );
    end

    fetch_merge i_fetch_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .order_valid (order_valid),
        .order_bank  (order_bank),
        .order_ready (order_ready),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready),
        .epoch       (epoch),
        .out_valid   (out_valid),
        .out         (out),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

/* rtl/imem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_bank
    import fetch_pkg::*;
    import ctrl_pkg::*;
#(
    parameter bank_idx_t BANK_ID = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  fetch_req_t req,
    output logic       req_ready,
    output logic       rsp_valid,
    output fetch_rsp_t rsp,
    input  logic       rsp_ready,
    input  logic       load_valid,
    input  load_t      load
);

    localparam int ROW_LO = BANK_BITS + 2;

    logic [31:0] mem [BANK_DEPTH];
    fetch_req_t  q_req;
    fetch_req_t  s1_req;  // address stage
    fetch_req_t  s2_req;  // data stage
    logic [31:0] s2_instr;
    logic        q_valid;
    logic        s1_valid;
    logic        s2_valid;
    logic        advance;

    fetch_fifo #(
        .payload_t (fetch_req_t)
    ) i_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_data   (req),
        .in_ready  (req_ready),
        .out_valid (q_valid),
        .out_data  (q_req),
        .out_ready (advance),
        .flush     (1'b0)
    );

    assign advance = !s2_valid || rsp_ready; // both stages move together

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= q_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_req   <= q_req;
            s2_req   <= s1_req;
            s2_instr <= mem[s1_req.pc[ROW_LO +: ROW_BITS]];
        end
    end

    // boot load, other banks' words ignored
    always_ff @(posedge clk) begin
        if (load_valid && load.addr[BANK_BITS+1:2] == BANK_ID) begin
            mem[load.addr[ROW_LO +: ROW_BITS]] <= load.data;
        end
    end

    assign rsp_valid = s2_valid;
    assign rsp.pc    = s2_req.pc;
    assign rsp.instr = s2_instr;
    assign rsp.epoch = s2_req.epoch;

endmodule

`default_nettype wire

/* rtl/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen
    import fetch_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrl_t                ctrl,
    output fetch_req_t           req,
    output logic [NUM_BANKS-1:0] req_valid,
    input  logic [NUM_BANKS-1:0] req_ready,
    input  logic                 order_ready,
    output logic                 order_valid,
    output bank_idx_t            order_bank,
    output logic                 epoch
);

    logic [PC_WIDTH-1:0] pc;
    logic                issued; // a request went out since the last redirect
    bank_idx_t           bank;
    logic                issue;
    logic                fire;

    assign bank  = pc[BANK_BITS+1:2]; // word interleaved
    assign issue = !ctrl.hold && !ctrl.redirect && order_ready;
    assign fire  = issue && req_ready[bank];

    always_comb begin
        req_valid       = '0;
        req_valid[bank] = issue;
    end

    assign req.pc    = pc;
    assign req.epoch = epoch;

    // order entry goes in with the request
    assign order_valid = fire;
    assign order_bank  = bank;

    // A redirect with nothing issued since the last one leaves the epoch alone.
    // Everything in flight is already stale then, and a second toggle would
    // make it look current again.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= RESET_PC;
            epoch  <= 1'b0;
            issued <= 1'b0;
        end else if (ctrl.redirect) begin
            pc     <= ctrl.redirect_pc;
            epoch  <= epoch ^ issued;
            issued <= 1'b0;
        end else if (fire) begin
            pc     <= pc + PC_WIDTH'(4);
            issued <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src.f */
rtl/fetch_pkg.sv
rtl/ctrl_pkg.sv
rtl/fetch_fifo.sv
rtl/pc_gen.sv
rtl/imem_bank.sv
rtl/fetch_merge.sv
rtl/fetch_unit.sv
tests/tb_fetch_unit.sv

/* tests/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit
    import fetch_pkg::*;
    import ctrl_pkg::*;
();

    localparam int PERIOD      = 100;
    localparam int LOAD_WORDS  = NUM_BANKS * BANK_DEPTH;
    localparam int ACCEPTS     = 40 + 20 + 8 * 10 + 10 + 4 * 15 + 8; // summed over the tests
    localparam int STIM_CYCLES = LOAD_WORDS + 4 * ACCEPTS + 100;   // out_ready near 50% plus refills

    logic       clk;
    logic       rst_n;
    ctrl_t      ctrl;
    logic       load_valid;
    load_t      load;
    logic       out_valid;
    fetch_rsp_t out_rsp;
    logic       out_ready;
    logic       rdy_raw;
    logic       bp_mode; // random decode stalls

    logic [31:0] model [LOAD_WORDS];
    logic [31:0] exp_pc;
    int          acc_cnt = 0;
    int          idle_cnt;
    int          errors;
    int          err_start;
    int          pass_cnt;
    int          fail_cnt;
    string       test_name;

    fetch_unit i_fetch_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .load_valid (load_valid),
        .load       (load),
        .out_valid  (out_valid),
        .out        (out_rsp),
        .out_ready  (out_ready)
    );

    always #(PERIOD / 2) clk = ~clk;

    assign out_ready = rdy_raw && !ctrl.redirect; // decode takes nothing while execute redirects

    // expected program order
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc   <= RESET_PC;
            idle_cnt <= 0;
        end else begin
            if (ctrl.redirect) begin
                exp_pc <= ctrl.redirect_pc;
            end else if (out_valid && out_ready) begin
                exp_pc <= exp_pc + 32'd4;
            end
            idle_cnt <= (ctrl.hold && out_ready) ? idle_cnt + 1 : 0;
        end
    end

    always @(posedge clk) begin
        if (out_valid && out_ready) begin
            acc_cnt <= acc_cnt + 1;
        end
    end

    function automatic logic [31:0] model_word(input logic [31:0] pc);
        int unsigned idx;
        idx = ((pc - RESET_PC) >> 2) % LOAD_WORDS; // image repeats every 4 KB
        return model[idx];
    endfunction

    a_out_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (out_rsp.pc == exp_pc))
    else begin
        errors++;
        $display("Error: %s out.pc expected %h actual %h", test_name,
                 $sampled(exp_pc), $sampled(out_rsp.pc));
    end

    a_out_instr: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (out_rsp.instr == model_word(out_rsp.pc)))
    else begin
        errors++;
        $display("Error: %s out.instr expected %h actual %h", test_name,
                 model_word($sampled(out_rsp.pc)), $sampled(out_rsp.instr));
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready && !ctrl.redirect) |=> (out_valid && $stable(out_rsp)))
    else begin
        errors++;
        $display("%s: output changed or dropped while decode was stalled", test_name);
    end

    a_hold_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (idle_cnt >= 8) |-> !out_valid)
    else begin
        errors++;
        $display("%s: instruction still delivered long after hold was raised", test_name);
    end

    // mid-cycle sample, registers have settled after the reset edge
    a_reset_quiet: assert property (@(negedge clk)
        (!rst_n || $rose(rst_n)) |-> !out_valid)
    else begin
        errors++;
        $display("%s: out_valid high during or right after reset", test_name);
    end

    task automatic step();
        @(negedge clk);
        rdy_raw = bp_mode ? ($urandom % 2 == 1) : 1'b1;
    endtask

    task automatic wait_accepts(input int n);
        int target;
        target = acc_cnt + n;
        while (acc_cnt < target) begin
            step();
        end
    endtask

    function automatic logic [31:0] random_target();
        return RESET_PC + 32'(($urandom % 768) * 4); // leaves room to run on
    endfunction

    task automatic redirect_to(input logic [31:0] target);
        ctrl.redirect    = 1'b1;
        ctrl.redirect_pc = target;
        step();
        ctrl.redirect = 1'b0;
    endtask

    task automatic redirect_twice();
        ctrl.redirect    = 1'b1;
        ctrl.redirect_pc = random_target();
        step();
        ctrl.redirect_pc = random_target(); // second target on the next cycle wins
        step();
        ctrl.redirect = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        if (errors == err_start) begin
            pass_cnt++;
            $display("test %-12s ok", test_name);
        end else begin
            fail_cnt++;
            $display("test %-12s failed with %0d errors", test_name, errors - err_start);
        end
    endtask

    initial begin
        void'($urandom(53));
        clk        = 1'b0;
        rst_n      = 1'b0;
        ctrl       = '{hold: 1'b1, redirect: 1'b0, redirect_pc: 32'h0};
        load_valid = 1'b0;
        load       = '0;
        rdy_raw    = 1'b1;
        bp_mode    = 1'b0;
        errors     = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;

        begin_test("reset");
        repeat (2) @(posedge clk);
        step();
        rst_n = 1'b1;
        step();
        end_test();

        // boot image while fetch is held
        for (int i = 0; i < LOAD_WORDS; i++) begin
            load_valid = 1'b1;
            load.addr  = RESET_PC + 32'(i * 4);
            load.data  = $urandom;
            model[i]   = load.data;
            step();
        end
        load_valid = 1'b0;

        begin_test("sequential");
        ctrl.hold = 1'b0;
        wait_accepts(40);
        end_test();

        begin_test("hold");
        ctrl.hold = 1'b1;
        repeat (20) step();
        ctrl.hold = 1'b0;
        wait_accepts(20);
        end_test();

        begin_test("redirect");
        repeat (8) begin
            redirect_to(random_target());
            wait_accepts(10);
        end
        redirect_twice();
        wait_accepts(10);
        end_test();

        begin_test("backpressure");
        bp_mode = 1'b1;
        repeat (3) begin
            wait_accepts(15);
            redirect_to(random_target());
        end
        wait_accepts(15);
        bp_mode = 1'b0;
        end_test();

        begin_test("reset_run");
        rst_n = 1'b0; // mid-stream with fetch running
        repeat (2) step();
        rst_n = 1'b1;
        wait_accepts(8);
        end_test();

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(20 * STIM_CYCLES * PERIOD);
        $display("timeout: test %s stopped receiving instructions", test_name);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
